// ==== Bender.yml ====
package:
  name: simd_alu

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/simd_alu_pkg.sv
      - design/simd_alu_decode.sv
      - design/simd_alu_compare.sv
      - design/simd_alu_execute.sv
      - design/simd_alu_result.sv
      - design/simd_alu_top.sv
  - target: simulation
    include_dirs:
      - design
      - sim
    files:
      - sim/simd_alu_tb.sv

// ==== design/simd_alu_compare.sv ====
// Per-element comparator of the SIMD ALU, feeds min/max selection and the compare result
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_compare import simd_alu_pkg::*; (
  input  alu_data_t                  operand_a_i,
  input  alu_data_t                  operand_b_i,
  input  vew_e                       vew_i,
  input  logic                       signed_i,
  output logic [`SIMD_ALU_BYTES-1:0] less_o,
  output logic [`SIMD_ALU_BYTES-1:0] equal_o
);

  // One candidate per element width
  logic [`SIMD_ALU_BYTES-1:0] less_w  [4];
  logic [`SIMD_ALU_BYTES-1:0] equal_w [4];

  ////////////////////
  // Element compare
  ////////////////////

  for (genvar g = 0; g < 4; g++) begin : gen_ew
    localparam int unsigned W   = 8 << g;
    localparam int unsigned N   = `SIMD_ALU_DATA_W / W;
    localparam int unsigned BPE = W / 8;

    always_comb begin
      logic [W-1:0] a;
      logic [W-1:0] b;

      less_w[g]  = '0;
      equal_w[g] = '0;
      a          = '0;
      b          = '0;
      for (int e = 0; e < N; e++) begin
        a = operand_a_i[e*W +: W];
        b = operand_b_i[e*W +: W];
        // One extra bit, sign when signed_i, zero otherwise
        less_w[g][e*BPE] = $signed({signed_i & b[W-1], b}) <
                           $signed({signed_i & a[W-1], a});
        equal_w[g][e*BPE] = (a == b);
      end
    end
  end

  // Only the active width reaches the outputs
  assign less_o  = less_w[vew_i];
  assign equal_o = equal_w[vew_i];

endmodule

// ==== design/simd_alu_consts.svh ====
// Datapath width and count macros, included by the SIMD ALU package and every RTL module
`ifndef SIMD_ALU_CONSTS_SVH
`define SIMD_ALU_CONSTS_SVH

// One register word
`define SIMD_ALU_DATA_W 64

// Byte lanes per word, also the largest element count
`define SIMD_ALU_BYTES 8

// Opcode field
`define SIMD_ALU_OP_W 5

// Element width code
`define SIMD_ALU_EW_W 2

`endif

// ==== design/simd_alu_decode.sv ====
// Opcode decoder of the SIMD ALU, gives the operation class and control flags to the datapath
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_decode import simd_alu_pkg::*; (
  input  alu_op_e    op_i,
  output alu_class_e cls_o,
  output logic       signed_o,
  output logic       sat_o,
  output logic       swap_o,
  output logic       invert_o,
  output logic       or_equal_o,
  output logic       eq_only_o
);

  always_comb begin
    cls_o      = CLS_LOGIC;
    signed_o   = 1'b0;
    sat_o      = 1'b0;
    swap_o     = 1'b0;
    invert_o   = 1'b0;
    or_equal_o = 1'b0;
    eq_only_o  = 1'b0;

    unique case (op_i)
      // Logic operator picked by invert and signed
      VAND: cls_o = CLS_LOGIC;
      VOR: begin
        cls_o    = CLS_LOGIC;
        signed_o = 1'b1;
      end
      VXOR: begin
        cls_o    = CLS_LOGIC;
        invert_o = 1'b1;
      end

      VADD:   cls_o = CLS_ADD;
      VSUB:   cls_o = CLS_SUB;
      VRSUB:  {cls_o, swap_o} = {CLS_SUB, 1'b1};
      VSADDU: {cls_o, sat_o} = {CLS_ADD, 1'b1};
      VSADD:  {cls_o, sat_o, signed_o} = {CLS_ADD, 2'b11};
      VSSUBU: {cls_o, sat_o} = {CLS_SUB, 1'b1};
      VSSUB:  {cls_o, sat_o, signed_o} = {CLS_SUB, 2'b11};

      // Left shift marked by invert
      VSLL: {cls_o, invert_o} = {CLS_SHIFT, 1'b1};
      VSRL: cls_o = CLS_SHIFT;
      VSRA: {cls_o, signed_o} = {CLS_SHIFT, 1'b1};

      VMINU: cls_o = CLS_MINMAX;
      VMIN:  {cls_o, signed_o} = {CLS_MINMAX, 1'b1};
      VMAXU: {cls_o, invert_o} = {CLS_MINMAX, 1'b1};
      VMAX:  {cls_o, invert_o, signed_o} = {CLS_MINMAX, 2'b11};

      VMSEQ:  {cls_o, eq_only_o} = {CLS_CMP, 1'b1};
      VMSNE:  {cls_o, eq_only_o, invert_o} = {CLS_CMP, 2'b11};
      VMSLTU: cls_o = CLS_CMP;
      VMSLT:  {cls_o, signed_o} = {CLS_CMP, 1'b1};
      VMSLEU: {cls_o, or_equal_o} = {CLS_CMP, 1'b1};
      VMSLE:  {cls_o, or_equal_o, signed_o} = {CLS_CMP, 2'b11};
      VMSGTU: {cls_o, or_equal_o, invert_o} = {CLS_CMP, 2'b11};
      VMSGT:  {cls_o, or_equal_o, invert_o, signed_o} = {CLS_CMP, 3'b111};
      default: ;
    endcase
  end

endmodule

// ==== design/simd_alu_execute.sv ====
// Lane datapath of the SIMD ALU: logic, add/sub with saturation, shifts and min/max per element
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_execute import simd_alu_pkg::*; (
  input  alu_data_t                  operand_a_i,
  input  alu_data_t                  operand_b_i,
  input  vew_e                       vew_i,
  input  alu_class_e                 cls_i,
  input  logic                       signed_i,
  input  logic                       sat_i,
  input  logic                       swap_i,
  input  logic                       invert_i,
  input  logic [`SIMD_ALU_BYTES-1:0] less_i,
  output alu_data_t                  arith_o,
  output alu_sat_t                   arith_sat_o
);

  alu_data_t lane_res [4];
  alu_sat_t  lane_sat [4];

  ////////////////////
  // Lanes per width
  ////////////////////

  for (genvar g = 0; g < 4; g++) begin : gen_ew
    localparam int unsigned W   = 8 << g;
    localparam int unsigned N   = `SIMD_ALU_DATA_W / W;
    localparam int unsigned BPE = W / 8;
    localparam int unsigned SW  = 3 + g;

    always_comb begin
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] x;
      logic [W-1:0] y;
      logic [W-1:0] lane;
      logic [W:0]   ext;
      logic         ovf;

      lane_res[g] = '0;
      lane_sat[g] = '0;
      a           = '0;
      b           = '0;
      x           = '0;
      y           = '0;
      lane        = '0;
      ext         = '0;
      ovf         = 1'b0;

      for (int e = 0; e < N; e++) begin
        a    = operand_a_i[e*W +: W];
        b    = operand_b_i[e*W +: W];
        // Subtract computes y - x, b - a unless reversed
        x    = swap_i ? b : a;
        y    = swap_i ? a : b;
        lane = '0;
        ext  = '0;
        ovf  = 1'b0;

        unique case (cls_i)
          CLS_LOGIC: begin
            if (invert_i) begin
              lane = a ^ b;
            end else if (signed_i) begin
              lane = a | b;
            end else begin
              lane = a & b;
            end
          end

          CLS_ADD, CLS_SUB: begin
            if (cls_i == CLS_ADD) begin
              ext = {signed_i & a[W-1], a} + {signed_i & b[W-1], b};
            end else begin
              ext = {signed_i & y[W-1], y} - {signed_i & x[W-1], x};
            end
            // Signed overflow when the top two bits disagree
            if (sat_i) begin
              ovf = signed_i ? (ext[W] ^ ext[W-1]) : ext[W];
            end
            if (!ovf) begin
              lane = ext[W-1:0];
            end else if (signed_i) begin
              // True sign in ext[W] picks max or min
              lane = {ext[W], {(W-1){~ext[W]}}};
            end else begin
              // Carry clamps high, borrow clamps to zero
              lane = {W{cls_i == CLS_ADD}};
            end
          end

          CLS_SHIFT: begin
            if (invert_i) begin
              lane = b << a[SW-1:0];
            end else if (signed_i) begin
              lane = $signed(b) >>> a[SW-1:0];
            end else begin
              lane = b >> a[SW-1:0];
            end
          end

          // less flag sits at the element's first byte
          CLS_MINMAX: lane = (less_i[e*BPE] ^ invert_i) ? b : a;

          default: lane = '0;
        endcase

        lane_res[g][e*W +: W]     = lane;
        lane_sat[g][e*BPE +: BPE] = {BPE{ovf}};
      end
    end
  end

  assign arith_o     = lane_res[vew_i];
  assign arith_sat_o = lane_sat[vew_i];

endmodule

// ==== design/simd_alu_pkg.sv ====
// Shared types of the SIMD ALU, imported by every RTL module and the testbench
`include "simd_alu_consts.svh"

package simd_alu_pkg;

  ////////////////////
  // Data words
  ////////////////////

  typedef logic [`SIMD_ALU_DATA_W-1:0] alu_data_t;

  // One flag per byte
  typedef logic [`SIMD_ALU_BYTES-1:0] alu_sat_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [`SIMD_ALU_EW_W-1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic [`SIMD_ALU_OP_W-1:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGT, VMSGTU
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_LOGIC,
    CLS_ADD,
    CLS_SUB,
    CLS_SHIFT,
    CLS_MINMAX,
    CLS_CMP
  } alu_class_e;

endpackage

// ==== design/simd_alu_result.sv ====
// Result stage of the SIMD ALU, forms compare words and holds the single output register
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_result import simd_alu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  vew_e                       vew_i,
  input  alu_class_e                 cls_i,
  input  logic                       invert_i,
  input  logic                       or_equal_i,
  input  logic                       eq_only_i,
  input  logic [`SIMD_ALU_BYTES-1:0] less_i,
  input  logic [`SIMD_ALU_BYTES-1:0] equal_i,
  input  alu_data_t                  arith_i,
  input  alu_sat_t                   arith_sat_i,
  output alu_data_t                  result_o,
  output alu_sat_t                   vxsat_o,
  output logic                       valid_o
);

  alu_data_t cmp_word;
  alu_data_t word_d;

  ////////////////////
  // Compare word
  ////////////////////

  always_comb begin
    int unsigned bpe;
    logic        hit;

    bpe      = 1 << vew_i;
    hit      = 1'b0;
    cmp_word = '0;
    for (int p = 0; p < `SIMD_ALU_BYTES; p++) begin
      if (eq_only_i) begin
        hit = equal_i[p];
      end else begin
        hit = less_i[p] | (or_equal_i & equal_i[p]);
      end
      // Boolean goes to bit 0 of each element
      if ((p % bpe) == 0) begin
        cmp_word[p*8] = hit ^ invert_i;
      end
    end
  end

  assign word_d = (cls_i == CLS_CMP) ? cmp_word : arith_i;

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o  <= valid_i;
      // Idle cycles present zeros
      result_o <= valid_i ? word_d : '0;
      vxsat_o  <= valid_i ? arith_sat_i : '0;
    end
  end

endmodule

// ==== design/simd_alu_top.sv ====
// Top level of the registered SIMD ALU, result appears one cycle after a valid operation
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_top import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      valid_i,
  input  alu_data_t operand_a_i,
  input  alu_data_t operand_b_i,
  input  alu_op_e   op_i,
  input  vew_e      vew_i,
  output alu_data_t result_o,
  output alu_sat_t  vxsat_o,
  output logic      valid_o
);

  alu_class_e                 cls;
  logic                       is_signed;
  logic                       is_sat;
  logic                       swap;
  logic                       invert;
  logic                       or_equal;
  logic                       eq_only;
  logic [`SIMD_ALU_BYTES-1:0] less;
  logic [`SIMD_ALU_BYTES-1:0] equal;
  alu_data_t                  arith;
  alu_sat_t                   arith_sat;

  simd_alu_decode u_decode (
    .op_i       (op_i),
    .cls_o      (cls),
    .signed_o   (is_signed),
    .sat_o      (is_sat),
    .swap_o     (swap),
    .invert_o   (invert),
    .or_equal_o (or_equal),
    .eq_only_o  (eq_only)
  );

  simd_alu_compare u_compare (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .vew_i       (vew_i),
    .signed_i    (is_signed),
    .less_o      (less),
    .equal_o     (equal)
  );

  simd_alu_execute u_execute (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .vew_i       (vew_i),
    .cls_i       (cls),
    .signed_i    (is_signed),
    .sat_i       (is_sat),
    .swap_i      (swap),
    .invert_i    (invert),
    .less_i      (less),
    .arith_o     (arith),
    .arith_sat_o (arith_sat)
  );

  simd_alu_result u_result (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .vew_i       (vew_i),
    .cls_i       (cls),
    .invert_i    (invert),
    .or_equal_i  (or_equal),
    .eq_only_i   (eq_only),
    .less_i      (less),
    .equal_i     (equal),
    .arith_i     (arith),
    .arith_sat_i (arith_sat),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o),
    .valid_o     (valid_o)
  );

endmodule

// ==== files.f ====
+incdir+design
+incdir+sim
design/simd_alu_pkg.sv
design/simd_alu_decode.sv
design/simd_alu_compare.sv
design/simd_alu_execute.sv
design/simd_alu_result.sv
design/simd_alu_top.sv
sim/simd_alu_tb.sv

// ==== sim/simd_alu_model.svh ====
// Reference model of the SIMD ALU, included by the testbench to predict result words and flags
`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

typedef logic signed [127:0] wide_t;

function automatic logic [63:0] elem_mask(input int w);
  return (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
endfunction

// Element as a plain number, negative when signed and the top bit is set
function automatic wide_t elem_value(input logic [63:0] x, input int w, input bit is_signed);
  wide_t v;

  v = {64'd0, x & elem_mask(w)};
  if (is_signed && x[w-1]) begin
    v = v - (wide_t'(1) << w);
  end
  return v;
endfunction

function automatic void predict_result(input alu_op_e op, input vew_e vew,
                                       input logic [63:0] a, input logic [63:0] b,
                                       output logic [63:0] word, output logic [7:0] sat);
  int          w;
  int          bpe;
  int          sh;
  bit          sgn;
  logic [63:0] m;
  logic [63:0] ea;
  logic [63:0] eb;
  wide_t       va;
  wide_t       vb;
  wide_t       r;
  wide_t       hi;
  wide_t       lo;

  w    = 8 << vew;
  bpe  = w / 8;
  m    = elem_mask(w);
  sgn  = op inside {VSADD, VSSUB, VSRA, VMIN, VMAX, VMSLT, VMSLE, VMSGT};
  hi   = sgn ? wide_t'(m >> 1) : wide_t'(m);
  lo   = sgn ? -hi - 1 : wide_t'(0);
  word = '0;
  sat  = '0;
  for (int e = 0; e < 64 / w; e++) begin
    ea = (a >> (e * w)) & m;
    eb = (b >> (e * w)) & m;
    va = elem_value(ea, w, sgn);
    vb = elem_value(eb, w, sgn);
    sh = int'(ea & (w - 1));
    case (op)
      VAND:                 r = ea & eb;
      VOR:                  r = ea | eb;
      VXOR:                 r = ea ^ eb;
      VADD, VSADDU, VSADD:  r = va + vb;
      VSUB, VSSUBU, VSSUB:  r = vb - va;
      VRSUB:                r = va - vb;
      VSLL:                 r = eb << sh;
      VSRL:                 r = eb >> sh;
      VSRA:                 r = vb >>> sh;
      VMINU, VMIN:          r = (vb < va) ? vb : va;
      VMAXU, VMAX:          r = (vb > va) ? vb : va;
      VMSEQ:                r = (ea == eb);
      VMSNE:                r = (ea != eb);
      VMSLTU, VMSLT:        r = (vb < va);
      VMSLEU, VMSLE:        r = (vb <= va);
      VMSGTU, VMSGT:        r = (vb > va);
      default:              r = 0;
    endcase
    // Saturating ops clamp to the element range and flag every byte of it
    if (op inside {VSADDU, VSADD, VSSUBU, VSSUB} && (r > hi || r < lo)) begin
      r = (r > hi) ? hi : lo;
      sat |= 8'(((16'd1 << bpe) - 16'd1) << (e * bpe));
    end
    word |= (r[63:0] & m) << (e * w);
  end
endfunction

`endif

// ==== sim/simd_alu_tb.sv ====
// Self-checking testbench of the SIMD ALU, runs directed corners then random ops and checks each cycle
`timescale 1ns/1ps
`include "simd_alu_consts.svh"

module simd_alu_tb import simd_alu_pkg::*; ();

  `include "simd_alu_model.svh"

  localparam int RESET_CYCLES = 8;
  localparam int OP_COUNT     = 25;
  localparam int RANDOM_OPS   = 1500;
  // 200 directed and 1500 random ops, plus reset, drain and margin
  localparam int MAX_CYCLES   = 2400;

  logic        clk;
  logic        reset;
  logic        valid_in;
  logic        valid_out;
  alu_op_e     op;
  vew_e        vew;
  alu_data_t   operand_a;
  alu_data_t   operand_b;
  alu_data_t   result;
  alu_sat_t    vxsat;
  logic        sent_valid;
  logic        exp_valid;
  logic        missing_exp;
  alu_data_t   exp_word;
  alu_sat_t    exp_sat;
  alu_data_t   word_q [$];
  alu_sat_t    sat_q  [$];
  int          cycles = 0;

  simd_alu_top dut0 (
    .clk_i       (clk),
    .reset_i     (reset),
    .valid_i     (valid_in),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .op_i        (op),
    .vew_i       (vew),
    .result_o    (result),
    .vxsat_o     (vxsat),
    .valid_o     (valid_out)
  );

  always #4 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic drive_op(input logic v, input alu_op_e o, input vew_e w,
                          input alu_data_t a, input alu_data_t b);
    alu_data_t word;
    alu_sat_t  sat;

    @(posedge clk);
    valid_in  <= v;
    op        <= o;
    vew       <= w;
    operand_a <= a;
    operand_b <= b;
    if (v) begin
      predict_result(o, w, a, b, word, sat);
      word_q.push_back(word);
      sat_q.push_back(sat);
    end
  endtask

  // Same value in every element: 0, ones, signed min, signed max, full shift, one
  function automatic alu_data_t corner_word(input int k, input vew_e w);
    int        width;
    alu_data_t elem;
    alu_data_t word;

    width = 8 << w;
    case (k)
      0:       elem = '0;
      1:       elem = '1;
      2:       elem = 64'd1 << (width - 1);
      3:       elem = (64'd1 << (width - 1)) - 64'd1;
      4:       elem = 64'(width - 1);
      default: elem = 64'd1;
    endcase
    word = '0;
    for (int e = 0; e < 64 / width; e++) begin
      word |= (elem & elem_mask(width)) << (e * width);
    end
    return word;
  endfunction

  ////////////////////
  // Checking
  ////////////////////

  // Valid as the DUT captures it at this edge
  always @(posedge clk) begin
    sent_valid <= reset ? 1'b0 : valid_in;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    exp_valid   = sent_valid;
    missing_exp = 1'b0;
    exp_word    = '0;
    exp_sat     = '0;
    if (valid_out) begin
      if (word_q.size() == 0) begin
        missing_exp = 1'b1;
      end else begin
        exp_word = word_q.pop_front();
        exp_sat  = sat_q.pop_front();
      end
    end
  end

  a_valid: assert property (@(posedge clk) disable iff (reset) valid_out == exp_valid)
    else report_failure($sformatf("error at %0t: valid_o expected %b got %b",
                                  $time, $sampled(exp_valid), $sampled(valid_out)));

  a_queue: assert property (@(posedge clk) disable iff (reset) !missing_exp)
    else report_failure("valid_o went high with no operation waiting for a result");

  a_result: assert property (@(posedge clk) disable iff (reset) result == exp_word)
    else report_failure($sformatf("error at %0t: result_o expected %h got %h",
                                  $time, $sampled(exp_word), $sampled(result)));

  a_vxsat: assert property (@(posedge clk) disable iff (reset) vxsat == exp_sat)
    else report_failure($sformatf("error at %0t: vxsat_o expected %h got %h",
                                  $time, $sampled(exp_sat), $sampled(vxsat)));

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      report_failure($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int        k;
    int        j;
    alu_data_t a;
    alu_data_t b;

    void'($urandom(32'hb478));
    clk       = 1'b0;
    reset     = 1'b1;
    valid_in  = 1'b0;
    op        = VAND;
    vew       = EW8;
    operand_a = '0;
    operand_b = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Two corner pairs per op and width, odd widths also get an equal pair
    for (int o = 0; o < OP_COUNT; o++) begin
      for (int w = 0; w < 4; w++) begin
        k = (o + w) % 6;
        j = (w % 2) ? (k + 3) % 6 : (k + 1) % 6;
        drive_op(1'b1, alu_op_e'(o), vew_e'(w),
                 corner_word(k, vew_e'(w)), corner_word((k + 2) % 6, vew_e'(w)));
        drive_op(1'b1, alu_op_e'(o), vew_e'(w),
                 corner_word((k + 3) % 6, vew_e'(w)), corner_word(j, vew_e'(w)));
      end
    end

    for (int i = 0; i < RANDOM_OPS; i++) begin
      a = {$urandom, $urandom};
      b = ($urandom_range(7) == 0) ? a : {$urandom, $urandom};
      drive_op($urandom_range(99) >= 20, alu_op_e'($urandom_range(OP_COUNT - 1)),
               vew_e'($urandom_range(3)), a, b);
    end
    drive_op(1'b0, VAND, EW8, '0, '0);
    repeat (3) @(posedge clk);

    if (word_q.size() != 0) begin
      report_failure("operations were still waiting for a result at the end of the run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule
